//--- byteSequencer.sv
`timescale 1ns/1ps

module byteSequencer #(
    parameter int addrWidth = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioFull,
    input  logic                   i_jobStart,
    input  logic [addrWidth-1:0]   i_jobAddr,
    input  memCtrlPkg::reqKind_e   i_jobKind,
    input  memCtrlPkg::accessLen_e i_jobLen,
    input  logic [31:0]            i_jobStoreData,
    output logic [addrWidth-1:0]   o_memAddr,
    output logic                   o_memRw,
    output logic [7:0]             o_memData,
    output logic                   o_issueValid,
    output logic                   o_issueLast,
    output logic [1:0]             o_issueLane
);
    logic       active;
    logic [1:0] byteIdx;
    logic [2:0] lastIdx;
    logic       stall;
    logic       running;
    logic       issue;
    logic       isLast;
    logic       isStore;

    assign stall = !i_rdy || i_ioFull;

    // the job is live from its start pulse on, so byte 0 goes out in that cycle
    assign running = active || i_jobStart;
    assign issue   = running && !stall;

    assign lastIdx = 3'(i_jobLen) - 3'd1;
    assign isLast  = {1'b0, byteIdx} == lastIdx;
    assign isStore = i_jobKind == memCtrlPkg::kindStore;

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            byteIdx <= 2'd0;
        end else if (issue) begin
            if (isLast) begin
                active  <= 1'b0;
                byteIdx <= 2'd0;
            end else begin
                active  <= 1'b1;
                byteIdx <= byteIdx + 2'd1;
            end
        end else if (i_jobStart) begin
            // start pulse fell into a stalled cycle
            active <= 1'b1;
        end
    end

    // quiet read on the RAM port when nothing is issued
    always_comb begin
        o_memAddr = '0;
        o_memRw   = memCtrlPkg::memRead;
        o_memData = 8'h00;
        if (issue) begin
            o_memAddr = i_jobAddr + addrWidth'(byteIdx);
            if (isStore) begin
                o_memRw   = memCtrlPkg::memWrite;
                o_memData = i_jobStoreData[{byteIdx, 3'b000} +: 8];
            end
        end
    end

    assign o_issueValid = issue;
    assign o_issueLast  = issue && isLast;
    assign o_issueLane  = byteIdx;

endmodule

//--- compile.f
memCtrlPkg.sv
reqArbiter.sv
byteSequencer.sv
wordAssembler.sv
memCtrl.sv
ramModel.sv
memCtrlTb.sv

//--- memCtrl.sv
`timescale 1ns/1ps

module memCtrl #(
    parameter int addrWidth = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioFull,

    // fetch client
    input  logic                   i_infEn,
    input  logic [addrWidth-1:0]   i_infAddr,
    output logic                   o_infDone,
    output logic [31:0]            o_infInst,

    // data client
    input  logic                   i_dcEn,
    input  logic                   i_dcStore,
    input  memCtrlPkg::accessLen_e i_dcLen,
    input  logic [addrWidth-1:0]   i_dcAddr,
    input  logic [31:0]            i_dcData,
    output logic                   o_dcDone,
    output logic [31:0]            o_dcData,

    // byte RAM
    input  logic [7:0]             i_memData,
    output logic [addrWidth-1:0]   o_memAddr,
    output logic                   o_memRw,
    output logic [7:0]             o_memData
);
    logic                   jobStart;
    logic [addrWidth-1:0]   jobAddr;
    memCtrlPkg::reqKind_e   jobKind;
    memCtrlPkg::accessLen_e jobLen;
    logic [31:0]            jobStoreData;
    logic                   jobDone;
    logic                   issueValid;
    logic                   issueLast;
    logic [1:0]             issueLane;

    reqArbiter #(
        .addrWidth(addrWidth)
    ) reqArbiter_i (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_ioFull      (i_ioFull),
        .i_infEn       (i_infEn),
        .i_infAddr     (i_infAddr),
        .i_dcEn        (i_dcEn),
        .i_dcStore     (i_dcStore),
        .i_dcLen       (i_dcLen),
        .i_dcAddr      (i_dcAddr),
        .i_dcData      (i_dcData),
        .i_jobDone     (jobDone),
        .o_jobStart    (jobStart),
        .o_jobAddr     (jobAddr),
        .o_jobKind     (jobKind),
        .o_jobLen      (jobLen),
        .o_jobStoreData(jobStoreData)
    );

    byteSequencer #(
        .addrWidth(addrWidth)
    ) byteSequencer_i (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_ioFull      (i_ioFull),
        .i_jobStart    (jobStart),
        .i_jobAddr     (jobAddr),
        .i_jobKind     (jobKind),
        .i_jobLen      (jobLen),
        .i_jobStoreData(jobStoreData),
        .o_memAddr     (o_memAddr),
        .o_memRw       (o_memRw),
        .o_memData     (o_memData),
        .o_issueValid  (issueValid),
        .o_issueLast   (issueLast),
        .o_issueLane   (issueLane)
    );

    wordAssembler wordAssembler_i (
        .clk         (clk),
        .rst         (rst),
        .i_jobKind   (jobKind),
        .i_memData   (i_memData),
        .i_issueValid(issueValid),
        .i_issueLast (issueLast),
        .i_issueLane (issueLane),
        .o_jobDone   (jobDone),
        .o_infDone   (o_infDone),
        .o_infInst   (o_infInst),
        .o_dcDone    (o_dcDone),
        .o_dcData    (o_dcData)
    );

endmodule

//--- memCtrlPkg.sv
package memCtrlPkg;

    // kind of the job currently owned by the controller
    typedef enum logic [1:0] {
        kindFetch = 2'd0,
        kindLoad  = 2'd1,
        kindStore = 2'd2
    } reqKind_e;

    // access length encoded as the byte count
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen_e;

    localparam int wordBytes = 4;

    // filled one byte lane at a time and handed out as a whole word
    typedef union packed {
        logic [31:0]                word;
        logic [wordBytes-1:0][7:0] lane;
    } memWord_u;

    // RAM read/write control
    localparam logic memRead  = 1'b0;
    localparam logic memWrite = 1'b1;

endpackage

//--- memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb;

    localparam int addrWidth = 16;

    logic                   clk;
    logic                   rst;
    logic                   rdy;
    logic                   ioFull;
    logic                   infEn;
    logic [addrWidth-1:0]   infAddr;
    logic                   infDone;
    logic [31:0]            infInst;
    logic                   dcEn;
    logic                   dcStore;
    memCtrlPkg::accessLen_e dcLen;
    logic [addrWidth-1:0]   dcAddr;
    logic [31:0]            dcData;
    logic                   dcDone;
    logic [31:0]            dcRdData;
    logic [7:0]             ramRdData;
    logic [addrWidth-1:0]   memAddr;
    logic                   memRw;
    logic [7:0]             memWrData;
    logic                   writeInStall;

    // one table entry per line of the tests file
    logic [8*16-1:0]      testName [$];
    logic [8*8-1:0]       testOp [$];
    logic [addrWidth-1:0] testAddr [$];
    int                   testLen [$];
    logic [31:0]          testData [$];
    logic [31:0]          testExpect [$];
    bit                   testStall [$];

    int cycleCount = 0;
    int cycleLimit = 100;

    memCtrl #(
        .addrWidth(addrWidth)
    ) memCtrl_i (
        .clk      (clk),
        .rst      (rst),
        .i_rdy    (rdy),
        .i_ioFull (ioFull),
        .i_infEn  (infEn),
        .i_infAddr(infAddr),
        .o_infDone(infDone),
        .o_infInst(infInst),
        .i_dcEn   (dcEn),
        .i_dcStore(dcStore),
        .i_dcLen  (dcLen),
        .i_dcAddr (dcAddr),
        .i_dcData (dcData),
        .o_dcDone (dcDone),
        .o_dcData (dcRdData),
        .i_memData(ramRdData),
        .o_memAddr(memAddr),
        .o_memRw  (memRw),
        .o_memData(memWrData)
    );

    ramModel #(
        .addrWidth(addrWidth)
    ) ram_i (
        .clk           (clk),
        .rst           (rst),
        .i_addr        (memAddr),
        .i_rw          (memRw),
        .i_data        (memWrData),
        .i_stall       (!rdy || ioFull),
        .o_data        (ramRdData),
        .o_writeInStall(writeInStall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task abortRun();
        $display("Test FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    always @(negedge clk) begin
        if (writeInStall) begin
            $display("RAM saw a write while the controller was stalled");
            abortRun();
        end
    end

    task checkWord(input logic [8*16-1:0] name, input logic [31:0] expected,
                   input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %0s expected %08h actual %08h", name, expected, actual);
            abortRun();
        end
    endtask

    task checkKind(input logic [8*16-1:0] name, input memCtrlPkg::reqKind_e expected,
                   input memCtrlPkg::reqKind_e actual);
        if (actual !== expected) begin
            $display("Error: %0s expected %s actual %s", name, expected.name(), actual.name());
            abortRun();
        end
    endtask

    task checkLevel(input logic [8*16-1:0] name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %0s expected %b actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic loadTests();
        int                   fd;
        int                   count;
        string                lineStr;
        logic [8*16-1:0]      nameBuf;
        logic [8*8-1:0]       opBuf;
        logic [addrWidth-1:0] addrBuf;
        int                   lenBuf;
        logic [31:0]          dataBuf;
        logic [31:0]          expBuf;
        int                   stallBuf;
        fd = $fopen("memCtrlTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open memCtrlTests.txt");
            abortRun();
        end
        while (!$feof(fd)) begin
            lineStr = "";
            count = $fgets(lineStr, fd);
            // skip blank and comment lines
            if (count > 1 && lineStr.getc(0) != "#") begin
                count = $sscanf(lineStr, "%s %s %h %d %h %h %d", nameBuf, opBuf, addrBuf,
                                lenBuf, dataBuf, expBuf, stallBuf);
                if (count == 7) begin
                    testName.push_back(nameBuf);
                    testOp.push_back(opBuf);
                    testAddr.push_back(addrBuf);
                    testLen.push_back(lenBuf);
                    testData.push_back(dataBuf);
                    testExpect.push_back(expBuf);
                    testStall.push_back(stallBuf != 0);
                end
            end
        end
        $fclose(fd);
        if (testName.size() == 0) begin
            $display("No tests were read from memCtrlTests.txt");
            abortRun();
        end
    endtask

    task automatic driveStall(input bit randomStall);
        if (randomStall) begin
            rdy    = ($urandom % 4) != 0;
            ioFull = ($urandom % 5) == 0;
        end else begin
            rdy    = 1'b1;
            ioFull = 1'b0;
        end
    endtask

    task automatic runTest(input int t);
        memCtrlPkg::reqKind_e expKinds [$];
        memCtrlPkg::reqKind_e gotKind;
        bit                   isBoth;
        bit                   isFetch;
        bit                   isStoreOp;
        bit                   dropData;
        bit                   dropFetch;
        int                   doneCount;
        isBoth    = testOp[t] == "both";
        isFetch   = testOp[t] == "fetch";
        isStoreOp = testOp[t] == "store";
        // data done always comes first when both are raised
        if (!isFetch) begin
            expKinds.push_back(isStoreOp ? memCtrlPkg::kindStore : memCtrlPkg::kindLoad);
            dcEn    = 1'b1;
            dcStore = isStoreOp;
            dcLen   = memCtrlPkg::accessLen_e'(testLen[t]);
            dcAddr  = testAddr[t];
            dcData  = isStoreOp ? testData[t] : 32'h0;
        end
        if (isFetch || isBoth) begin
            expKinds.push_back(memCtrlPkg::kindFetch);
            infEn   = 1'b1;
            infAddr = testAddr[t];
        end
        doneCount = 0;
        while (doneCount < expKinds.size()) begin
            driveStall(testStall[t]);
            @(negedge clk);
            dropData  = 1'b0;
            dropFetch = 1'b0;
            if (dcDone) begin
                gotKind = dcStore ? memCtrlPkg::kindStore : memCtrlPkg::kindLoad;
                checkKind(testName[t], expKinds[doneCount], gotKind);
                if (!dcStore) begin
                    checkWord(testName[t], testExpect[t], dcRdData);
                end
                doneCount++;
                dropData = 1'b1;
            end
            if (infDone) begin
                checkKind(testName[t], expKinds[doneCount], memCtrlPkg::kindFetch);
                // the data column holds the fetch word of a both test
                checkWord(testName[t], isBoth ? testData[t] : testExpect[t], infInst);
                doneCount++;
                dropFetch = 1'b1;
            end
            @(posedge clk);
            #1;
            if (dropData) begin
                dcEn = 1'b0;
            end
            if (dropFetch) begin
                infEn = 1'b0;
            end
        end
        driveStall(1'b0);
    endtask

    initial begin
        void'($urandom(32'h78e2_8f9a));
        rst     = 1'b1;
        rdy     = 1'b1;
        ioFull  = 1'b0;
        infEn   = 1'b0;
        infAddr = '0;
        dcEn    = 1'b0;
        dcStore = 1'b0;
        dcLen   = memCtrlPkg::lenByte;
        dcAddr  = '0;
        dcData  = 32'h0;
        loadTests();
        cycleLimit = 40 * testName.size() + 100;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // quiet port before the first request
        repeat (4) begin
            @(negedge clk);
            checkLevel("afterReset", 1'b0, infDone);
            checkLevel("afterReset", 1'b0, dcDone);
            checkLevel("afterReset", memCtrlPkg::memRead, memRw);
            @(posedge clk);
            #1;
        end
        for (int t = 0; t < testName.size(); t++) begin
            runTest(t);
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- memCtrlTests.txt
# name op addr len data expect stall (addr, data and expect in hex)
# both raises a load and a fetch at addr, and data holds the expected fetch word
fetchAligned fetch 0010 4 00000000 b6b7b4b5 0
fetchHigh fetch 0103 4 00000000 a2a1a0a7 0
loadByte load 0020 1 00000000 00000085 0
loadHalf load 0021 2 00000000 00008784 0
loadWord load 0033 4 00000000 93909196 0
storeByte store 0040 1 000000c3 00000000 0
afterByte load 0040 4 00000000 e6e7e4c3 0
storeHalf store 0051 2 0000beef 00000000 0
afterHalf load 0050 4 00000000 f6beeff5 0
storeWord store 0062 4 12345678 00000000 0
belowWord load 0061 2 00000000 000078c4 0
afterWord load 0063 4 00000000 c3123456 0
aboveWord load 0066 1 00000000 000000c3 0
bothQuiet both 0070 2 d6d7d4d5 0000d4d5 0
fetchStall fetch 0010 4 00000000 b6b7b4b5 1
storeStall store 0080 4 cafef00d 00000000 1
loadStall load 0080 4 00000000 cafef00d 1
byteStall load 0083 1 00000000 000000ca 1
storeByteStall store 0084 1 0000005a 00000000 1
halfStall load 0084 2 00000000 0000205a 1
bothStall both 0090 4 36373435 36373435 1
highStall load 1234 2 00000000 00008283 1

//--- ramModel.sv
`timescale 1ns/1ps

module ramModel #(
    parameter int addrWidth = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [addrWidth-1:0] i_addr,
    input  logic                 i_rw,
    input  logic [7:0]           i_data,
    input  logic                 i_stall,
    output logic [7:0]           o_data,
    output logic                 o_writeInStall
);
    localparam int memSize = 1 << addrWidth;

    logic [7:0] mem [0:memSize-1];
    logic [7:0] fill;

    // start pattern folds every address byte into the value
    initial begin
        for (int a = 0; a < memSize; a++) begin
            fill = 8'ha5;
            for (int b = 0; b < addrWidth; b += 8) begin
                fill = fill ^ 8'(a >> b);
            end
            mem[a] = fill;
        end
    end

    // one cycle read latency
    always @(posedge clk) begin
        if (i_rw == memCtrlPkg::memWrite) begin
            mem[i_addr] <= i_data;
        end
        o_data <= mem[i_addr];
    end

    // sticky once a write shows up in a stalled cycle
    always @(posedge clk) begin
        if (rst) begin
            o_writeInStall <= 1'b0;
        end else if (i_stall && i_rw == memCtrlPkg::memWrite) begin
            o_writeInStall <= 1'b1;
        end
    end

endmodule

//--- reqArbiter.sv
`timescale 1ns/1ps

module reqArbiter #(
    parameter int addrWidth = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioFull,
    input  logic                   i_infEn,
    input  logic [addrWidth-1:0]   i_infAddr,
    input  logic                   i_dcEn,
    input  logic                   i_dcStore,
    input  memCtrlPkg::accessLen_e i_dcLen,
    input  logic [addrWidth-1:0]   i_dcAddr,
    input  logic [31:0]            i_dcData,
    input  logic                   i_jobDone,
    output logic                   o_jobStart,
    output logic [addrWidth-1:0]   o_jobAddr,
    output memCtrlPkg::reqKind_e   o_jobKind,
    output memCtrlPkg::accessLen_e o_jobLen,
    output logic [31:0]            o_jobStoreData
);
    logic busy;
    logic stall;
    logic accept;

    assign stall  = !i_rdy || i_ioFull;
    assign accept = !busy && !stall && (i_dcEn || i_infEn);

    // one job at a time until the done pulse releases it
    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            o_jobStart <= 1'b0;
        end else begin
            o_jobStart <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (i_jobDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_jobKind <= memCtrlPkg::kindFetch;
            o_jobLen  <= memCtrlPkg::lenWord;
        end else if (accept) begin
            // data side has priority
            if (i_dcEn) begin
                o_jobKind <= i_dcStore ? memCtrlPkg::kindStore : memCtrlPkg::kindLoad;
                o_jobLen  <= i_dcLen;
            end else begin
                o_jobKind <= memCtrlPkg::kindFetch;
                o_jobLen  <= memCtrlPkg::lenWord;
            end
        end
    end

    // address and store data stay put until the job is done
    always_ff @(posedge clk) begin
        if (accept) begin
            if (i_dcEn) begin
                o_jobAddr      <= i_dcAddr;
                o_jobStoreData <= i_dcData;
            end else begin
                o_jobAddr      <= i_infAddr;
                o_jobStoreData <= 32'h0;
            end
        end
    end

endmodule

//--- wordAssembler.sv
`timescale 1ns/1ps

module wordAssembler (
    input  logic                 clk,
    input  logic                 rst,
    input  memCtrlPkg::reqKind_e i_jobKind,
    input  logic [7:0]           i_memData,
    input  logic                 i_issueValid,
    input  logic                 i_issueLast,
    input  logic [1:0]           i_issueLane,
    output logic                 o_jobDone,
    output logic                 o_infDone,
    output logic [31:0]          o_infInst,
    output logic                 o_dcDone,
    output logic [31:0]          o_dcData
);
    memCtrlPkg::memWord_u word;
    memCtrlPkg::memWord_u nextWord;

    logic       capValid;
    logic       capLast;
    logic [1:0] capLane;
    logic       isStore;
    logic       isFetch;
    logic       readDone;
    logic       storeDone;
    logic       finish;

    assign isStore = i_jobKind == memCtrlPkg::kindStore;
    assign isFetch = i_jobKind == memCtrlPkg::kindFetch;

    assign readDone  = capValid && capLast;
    assign storeDone = i_issueValid && i_issueLast && isStore;
    assign finish    = readDone || storeDone;

    // returned byte lands in the lane it was requested for
    always_comb begin
        nextWord = word;
        if (capValid) begin
            nextWord.lane[capLane] = i_memData;
        end
    end

    // read data shows up one cycle after its address
    always_ff @(posedge clk) begin
        if (rst) begin
            capValid <= 1'b0;
        end else begin
            capValid <= i_issueValid && !isStore;
        end
    end

    always_ff @(posedge clk) begin
        capLast <= i_issueLast;
        capLane <= i_issueLane;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            word      <= '0;
            o_jobDone <= 1'b0;
            o_infDone <= 1'b0;
            o_dcDone  <= 1'b0;
            o_infInst <= 32'h0;
            o_dcData  <= 32'h0;
        end else begin
            o_jobDone <= finish;
            o_infDone <= finish && isFetch;
            o_dcDone  <= finish && !isFetch;
            if (readDone) begin
                // empty again so the next short load comes out zero-extended
                word <= '0;
                if (isFetch) begin
                    o_infInst <= nextWord.word;
                end else begin
                    o_dcData <= nextWord.word;
                end
            end else begin
                word <= nextWord;
            end
        end
    end

endmodule
